/* logic/dbg_params.svh */
`ifndef DBG_PARAMS_SVH
`define DBG_PARAMS_SVH

// debug ring sizing
`define DBG_FLIT_WIDTH 16
`define DBG_NUM_TILES 4

// ring addresses, tile i sits at base plus i
`define DBG_HOST_ID 0
`define DBG_MOD_BASE_ID 1

`define DBG_STATION_DEPTH 4

`endif

/* logic/dii_pkg.sv */
`include "dbg_params.svh"

package dii_pkg;

  typedef struct packed {
    logic [`DBG_FLIT_WIDTH-1:0] data;
    logic                       last;
  } dii_flit;

  // only REG packets are generated on this ring
  typedef enum logic [1:0] {
    REG   = 2'b00,
    EVENT = 2'b01
  } pkt_type_e;

  // header flit 2, type on top and subtype in the low nibble
  function automatic logic [`DBG_FLIT_WIDTH-1:0] type_word(
    pkt_type_e  ptype,
    logic [3:0] subtype
  );
    return {ptype, {(`DBG_FLIT_WIDTH - 6){1'b0}}, subtype};
  endfunction

endpackage

/* logic/dbg_reg_pkg.sv */
package dbg_reg_pkg;

  typedef enum logic [3:0] {
    REQ_READ       = 4'h0,
    REQ_WRITE      = 4'h1,
    RESP_READ_OK   = 4'h8,
    RESP_READ_ERR  = 4'h9,
    RESP_WRITE_OK  = 4'ha,
    RESP_WRITE_ERR = 4'hb
  } reg_subtype_e;

  typedef enum logic [15:0] {
    REG_MOD_ID      = 16'h0000,
    REG_MOD_VERSION = 16'h0001,
    REG_SCRATCH     = 16'h0200
  } reg_addr_e;

  typedef enum logic [2:0] {
    MOD_IDLE,
    MOD_HDR_SRC,
    MOD_HDR_TYPE,
    MOD_ADDR,
    MOD_WDATA,
    MOD_RESP
  } mod_state_e;

  typedef enum logic [1:0] {
    HOST_IDLE,
    HOST_SEND,
    HOST_WAIT,
    HOST_RECV
  } host_state_e;

endpackage

/* logic/dii_channel_if.sv */
// one flit stream of the debug ring
interface dii_channel_if;

  dii_pkg::dii_flit flit;
  logic             valid;
  logic             ready;

  modport sender (
    output flit,
    output valid,
    input  ready
  );

  modport receiver (
    input  flit,
    input  valid,
    output ready
  );

endinterface

/* logic/host_port.sv */
`include "dbg_params.svh"

module host_port (
  input  logic                       clk,
  input  logic                       arst_n_i,
  input  logic                       req_valid_i,
  input  logic                       req_write_i,
  input  logic [`DBG_FLIT_WIDTH-1:0] req_dest_i,
  input  logic [`DBG_FLIT_WIDTH-1:0] req_addr_i,
  input  logic [`DBG_FLIT_WIDTH-1:0] req_wdata_i,
  output logic                       req_ready_o,
  output logic                       rsp_valid_o,
  output logic [`DBG_FLIT_WIDTH-1:0] rsp_src_o,
  output dbg_reg_pkg::reg_subtype_e  rsp_subtype_o,
  output logic [`DBG_FLIT_WIDTH-1:0] rsp_data_o,
  output logic                       rsp_undeliverable_o,
  dii_channel_if.sender              ring_out,
  dii_channel_if.receiver            ring_in
);

  localparam logic [`DBG_FLIT_WIDTH-1:0] HOST_ID = `DBG_FLIT_WIDTH'(`DBG_HOST_ID);

  dbg_reg_pkg::host_state_e   state_q;
  dbg_reg_pkg::reg_subtype_e  sub_q;
  logic                       write_q;
  logic [`DBG_FLIT_WIDTH-1:0] dest_q;
  logic [`DBG_FLIT_WIDTH-1:0] addr_q;
  logic [`DBG_FLIT_WIDTH-1:0] wdata_q;
  logic [`DBG_FLIT_WIDTH-1:0] src_q;
  logic [`DBG_FLIT_WIDTH-1:0] data_q;
  logic [2:0]                 tx_idx_q;
  logic [2:0]                 rx_idx_q;
  logic                       accept;
  logic                       tx_fire;
  logic                       rx_fire;
  logic                       tx_last;

  assign accept  = req_valid_i && req_ready_o;
  assign tx_fire = ring_out.valid && ring_out.ready;
  assign rx_fire = ring_in.valid && ring_in.ready;
  // four flits for a read, five for a write
  assign tx_last = (tx_idx_q == (write_q ? 3'd4 : 3'd3));

  assign ring_out.valid = (state_q == dbg_reg_pkg::HOST_SEND);
  assign ring_in.ready  = (state_q == dbg_reg_pkg::HOST_WAIT) ||
                          (state_q == dbg_reg_pkg::HOST_RECV);

  always_comb begin
    ring_out.flit.last = tx_last;
    case (tx_idx_q)
      3'd0: ring_out.flit.data = dest_q;
      3'd1: ring_out.flit.data = HOST_ID;
      3'd2: ring_out.flit.data = dii_pkg::type_word(dii_pkg::REG,
                                   write_q ? dbg_reg_pkg::REQ_WRITE : dbg_reg_pkg::REQ_READ);
      3'd3: ring_out.flit.data = addr_q;
      default: ring_out.flit.data = wdata_q;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= dbg_reg_pkg::HOST_IDLE;
      req_ready_o <= 1'b0;
      rsp_valid_o <= 1'b0;
      tx_idx_q    <= '0;
      rx_idx_q    <= '0;
    end else begin
      rsp_valid_o <= 1'b0;
      case (state_q)
        dbg_reg_pkg::HOST_IDLE: begin
          req_ready_o <= !accept;
          tx_idx_q    <= '0;
          if (accept) begin
            state_q <= dbg_reg_pkg::HOST_SEND;
          end
        end
        dbg_reg_pkg::HOST_SEND: begin
          if (tx_fire) begin
            tx_idx_q <= tx_idx_q + 3'd1;
            if (tx_last) begin
              state_q <= dbg_reg_pkg::HOST_WAIT;
            end
          end
        end
        dbg_reg_pkg::HOST_WAIT: begin
          // destination flit of the returning packet
          if (rx_fire) begin
            rx_idx_q <= 3'd1;
            state_q  <= dbg_reg_pkg::HOST_RECV;
          end
        end
        default: begin
          if (rx_fire) begin
            rx_idx_q <= rx_idx_q + 3'd1;
            if (ring_in.flit.last) begin
              state_q     <= dbg_reg_pkg::HOST_IDLE;
              rsp_valid_o <= 1'b1;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      write_q <= req_write_i;
      dest_q  <= req_dest_i;
      addr_q  <= req_addr_i;
      wdata_q <= req_wdata_i;
    end
    if (rx_fire && state_q == dbg_reg_pkg::HOST_WAIT) begin
      data_q <= '0;
    end
    if (rx_fire && state_q == dbg_reg_pkg::HOST_RECV) begin
      case (rx_idx_q)
        3'd1: src_q <= ring_in.flit.data;
        3'd2: sub_q <= dbg_reg_pkg::reg_subtype_e'(ring_in.flit.data[3:0]);
        3'd3: begin
          if (sub_q == dbg_reg_pkg::RESP_READ_OK) begin
            data_q <= ring_in.flit.data;
          end
        end
        default: ;
      endcase
    end
  end

  // a request subtype coming back means no tile took it
  assign rsp_undeliverable_o = (sub_q == dbg_reg_pkg::REQ_READ) ||
                               (sub_q == dbg_reg_pkg::REQ_WRITE);
  assign rsp_src_o           = rsp_undeliverable_o ? HOST_ID : src_q;
  assign rsp_subtype_o       = sub_q;
  assign rsp_data_o          = data_q;

endmodule

/* logic/ring_station.sv */
`include "dbg_params.svh"

module ring_station #(
  parameter logic [`DBG_FLIT_WIDTH-1:0] ID    = `DBG_FLIT_WIDTH'(`DBG_MOD_BASE_ID),
  parameter int                         DEPTH = `DBG_STATION_DEPTH
) (
  input  logic            clk,
  input  logic            arst_n_i,
  dii_channel_if.receiver ring_in,
  dii_channel_if.sender   ring_out,
  dii_channel_if.sender   local_out,
  dii_channel_if.receiver local_in
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  dii_pkg::dii_flit mem [DEPTH];
  dii_pkg::dii_flit head;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             not_empty;
  logic             push;
  logic             pop;
  logic             fwd_busy_q;
  logic             fwd_local_q;
  logic             head_local;
  logic             ring_req;
  logic             own_fwd_q;
  logic             own_loc_q;
  logic             sel_fwd;
  logic             sel_loc;

  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign not_empty     = (count_q != '0);
  assign ring_in.ready = (count_q != CNT_W'(DEPTH));
  assign push          = ring_in.valid && ring_in.ready;
  assign head          = mem[rd_ptr_q];

  // route decided on the first flit and held to the last
  assign head_local = fwd_busy_q ? fwd_local_q : (head.data == ID);
  assign ring_req   = not_empty && !head_local;

  // ring_out keeps one source until that packet's last flit
  assign sel_fwd = own_fwd_q || (!own_loc_q && ring_req);
  assign sel_loc = own_loc_q || (!own_fwd_q && !ring_req && local_in.valid);

  assign ring_out.valid = sel_fwd ? not_empty : (sel_loc && local_in.valid);
  assign ring_out.flit  = sel_loc ? local_in.flit : head;
  assign local_in.ready = sel_loc && ring_out.ready;

  assign local_out.valid = not_empty && head_local;
  assign local_out.flit  = head;

  assign pop = head_local ? (local_out.valid && local_out.ready)
                          : (sel_fwd && ring_out.valid && ring_out.ready);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      fwd_busy_q  <= 1'b0;
      fwd_local_q <= 1'b0;
      own_fwd_q   <= 1'b0;
      own_loc_q   <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q    <= next_ptr(rd_ptr_q);
        fwd_busy_q  <= !head.last;
        fwd_local_q <= head_local;
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);

      // lock the owner from its first offered flit
      if (ring_out.valid && ring_out.ready && ring_out.flit.last) begin
        own_fwd_q <= 1'b0;
        own_loc_q <= 1'b0;
      end else if (ring_out.valid) begin
        own_fwd_q <= sel_fwd;
        own_loc_q <= sel_loc;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr_q] <= ring_in.flit;
    end
  end

endmodule

/* logic/tile_debug_module.sv */
`include "dbg_params.svh"

module tile_debug_module #(
  parameter logic [`DBG_FLIT_WIDTH-1:0] ID = `DBG_FLIT_WIDTH'(`DBG_MOD_BASE_ID)
) (
  input  logic            clk,
  input  logic            arst_n_i,
  dii_channel_if.receiver req_in,
  dii_channel_if.sender   rsp_out
);

  dbg_reg_pkg::mod_state_e    state_q;
  dbg_reg_pkg::reg_subtype_e  rsp_sub_q;
  logic                       is_write_q;
  logic [`DBG_FLIT_WIDTH-1:0] src_q;
  logic [`DBG_FLIT_WIDTH-1:0] addr_q;
  logic [`DBG_FLIT_WIDTH-1:0] rdata_q;
  logic [`DBG_FLIT_WIDTH-1:0] scratch_q;
  logic [1:0]                 tx_idx_q;
  logic                       rx_fire;
  logic                       tx_fire;
  logic                       tx_last;
  logic                       scratch_we;
  logic [`DBG_FLIT_WIDTH-1:0] rd_value;
  logic                       rd_ok;

  assign req_in.ready  = (state_q != dbg_reg_pkg::MOD_RESP);
  assign rsp_out.valid = (state_q == dbg_reg_pkg::MOD_RESP);
  assign rx_fire       = req_in.valid && req_in.ready;
  assign tx_fire       = rsp_out.valid && rsp_out.ready;
  // read-ok carries one extra data flit
  assign tx_last       = (tx_idx_q == ((rsp_sub_q == dbg_reg_pkg::RESP_READ_OK) ? 2'd3 : 2'd2));
  assign scratch_we    = is_write_q && (addr_q == dbg_reg_pkg::REG_SCRATCH);

  // register file read on the address flit
  always_comb begin
    rd_ok    = 1'b1;
    rd_value = '0;
    case (req_in.flit.data)
      dbg_reg_pkg::REG_MOD_ID:      rd_value = ID;
      dbg_reg_pkg::REG_MOD_VERSION: rd_value = `DBG_FLIT_WIDTH'(1);
      dbg_reg_pkg::REG_SCRATCH:     rd_value = scratch_q;
      default:                      rd_ok = 1'b0;
    endcase
  end

  always_comb begin
    rsp_out.flit.last = tx_last;
    case (tx_idx_q)
      2'd0: rsp_out.flit.data = src_q;
      2'd1: rsp_out.flit.data = ID;
      2'd2: rsp_out.flit.data = dii_pkg::type_word(dii_pkg::REG, rsp_sub_q);
      default: rsp_out.flit.data = rdata_q;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= dbg_reg_pkg::MOD_IDLE;
      tx_idx_q  <= '0;
      scratch_q <= '0;
    end else begin
      case (state_q)
        dbg_reg_pkg::MOD_IDLE: begin
          if (rx_fire) state_q <= dbg_reg_pkg::MOD_HDR_SRC;
        end
        dbg_reg_pkg::MOD_HDR_SRC: begin
          if (rx_fire) state_q <= dbg_reg_pkg::MOD_HDR_TYPE;
        end
        dbg_reg_pkg::MOD_HDR_TYPE: begin
          if (rx_fire) state_q <= dbg_reg_pkg::MOD_ADDR;
        end
        dbg_reg_pkg::MOD_ADDR: begin
          if (rx_fire) begin
            state_q <= req_in.flit.last ? dbg_reg_pkg::MOD_RESP : dbg_reg_pkg::MOD_WDATA;
          end
        end
        dbg_reg_pkg::MOD_WDATA: begin
          if (rx_fire) begin
            if (scratch_we) scratch_q <= req_in.flit.data;
            if (req_in.flit.last) state_q <= dbg_reg_pkg::MOD_RESP;
          end
        end
        default: begin
          if (tx_fire) begin
            tx_idx_q <= tx_last ? 2'd0 : tx_idx_q + 2'd1;
            if (tx_last) state_q <= dbg_reg_pkg::MOD_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rx_fire) begin
      case (state_q)
        dbg_reg_pkg::MOD_HDR_SRC:  src_q <= req_in.flit.data;
        dbg_reg_pkg::MOD_HDR_TYPE: is_write_q <= (req_in.flit.data[3:0] == dbg_reg_pkg::REQ_WRITE);
        dbg_reg_pkg::MOD_ADDR: begin
          addr_q  <= req_in.flit.data;
          rdata_q <= rd_value;
          // write without data flit ends here as an error
          if (is_write_q) begin
            rsp_sub_q <= dbg_reg_pkg::RESP_WRITE_ERR;
          end else begin
            rsp_sub_q <= rd_ok ? dbg_reg_pkg::RESP_READ_OK : dbg_reg_pkg::RESP_READ_ERR;
          end
        end
        dbg_reg_pkg::MOD_WDATA: begin
          rsp_sub_q <= scratch_we ? dbg_reg_pkg::RESP_WRITE_OK : dbg_reg_pkg::RESP_WRITE_ERR;
        end
        default: ;
      endcase
    end
  end

endmodule

/* logic/debug_ring_2x2.sv */
`include "dbg_params.svh"

module debug_ring_2x2 (
  input  logic                       clk,
  input  logic                       arst_n_i,
  input  logic                       req_valid_i,
  input  logic                       req_write_i,
  input  logic [`DBG_FLIT_WIDTH-1:0] req_dest_i,
  input  logic [`DBG_FLIT_WIDTH-1:0] req_addr_i,
  input  logic [`DBG_FLIT_WIDTH-1:0] req_wdata_i,
  output logic                       req_ready_o,
  output logic                       rsp_valid_o,
  output logic [`DBG_FLIT_WIDTH-1:0] rsp_src_o,
  output dbg_reg_pkg::reg_subtype_e  rsp_subtype_o,
  output logic [`DBG_FLIT_WIDTH-1:0] rsp_data_o,
  output logic                       rsp_undeliverable_o
);

  // position of each tile along the meander host, 0, 1, 3, 2, host
  localparam int RING_POS [`DBG_NUM_TILES] = '{0, 1, 3, 2};

  // ring_link[k] feeds hop k, the last one returns to the host
  dii_channel_if ring_link [`DBG_NUM_TILES + 1] ();
  dii_channel_if to_mod    [`DBG_NUM_TILES] ();
  dii_channel_if from_mod  [`DBG_NUM_TILES] ();

  host_port u_host_port (
    .clk                 (clk),
    .arst_n_i            (arst_n_i),
    .req_valid_i         (req_valid_i),
    .req_write_i         (req_write_i),
    .req_dest_i          (req_dest_i),
    .req_addr_i          (req_addr_i),
    .req_wdata_i         (req_wdata_i),
    .req_ready_o         (req_ready_o),
    .rsp_valid_o         (rsp_valid_o),
    .rsp_src_o           (rsp_src_o),
    .rsp_subtype_o       (rsp_subtype_o),
    .rsp_data_o          (rsp_data_o),
    .rsp_undeliverable_o (rsp_undeliverable_o),
    .ring_out            (ring_link[0]),
    .ring_in             (ring_link[`DBG_NUM_TILES])
  );

  for (genvar i = 0; i < `DBG_NUM_TILES; i++) begin : gen_station
    localparam int POS = RING_POS[i];

    ring_station #(
      .ID    (`DBG_FLIT_WIDTH'(`DBG_MOD_BASE_ID + i)),
      .DEPTH (`DBG_STATION_DEPTH)
    ) u_station (
      .clk       (clk),
      .arst_n_i  (arst_n_i),
      .ring_in   (ring_link[POS]),
      .ring_out  (ring_link[POS + 1]),
      .local_out (to_mod[i]),
      .local_in  (from_mod[i])
    );
  end

  for (genvar i = 0; i < `DBG_NUM_TILES; i++) begin : gen_mod
    tile_debug_module #(
      .ID (`DBG_FLIT_WIDTH'(`DBG_MOD_BASE_ID + i))
    ) u_mod (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .req_in   (to_mod[i]),
      .rsp_out  (from_mod[i])
    );
  end

endmodule

/* testbench/tb_debug_ring.sv */
`include "dbg_params.svh"

module tb_debug_ring;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 100;
  localparam int NUM_DIRECTED = 30;
  localparam int NUM_RANDOM   = 200;
  localparam int NUM_REQS     = NUM_DIRECTED + NUM_RANDOM;
  localparam logic [`DBG_FLIT_WIDTH-1:0] UNLISTED_ADDR = 16'h0123;
  localparam logic [`DBG_FLIT_WIDTH-1:0] LOST_DEST     = 16'd9;

  typedef struct {
    dbg_reg_pkg::reg_subtype_e  subtype;
    logic [`DBG_FLIT_WIDTH-1:0] src;
    logic [`DBG_FLIT_WIDTH-1:0] data;
    logic                       undeliverable;
  } exp_rsp_t;

  logic                       clk;
  logic                       arst_n_i;
  logic                       req_valid_i;
  logic                       req_write_i;
  logic [`DBG_FLIT_WIDTH-1:0] req_dest_i;
  logic [`DBG_FLIT_WIDTH-1:0] req_addr_i;
  logic [`DBG_FLIT_WIDTH-1:0] req_wdata_i;
  logic                       req_ready_o;
  logic                       rsp_valid_o;
  logic [`DBG_FLIT_WIDTH-1:0] rsp_src_o;
  dbg_reg_pkg::reg_subtype_e  rsp_subtype_o;
  logic [`DBG_FLIT_WIDTH-1:0] rsp_data_o;
  logic                       rsp_undeliverable_o;

  logic [31:0]                lfsr_state;
  logic [`DBG_FLIT_WIDTH-1:0] scratch_model [`DBG_NUM_TILES];
  exp_rsp_t                   exp_q [$];
  int                         issued;
  int                         received;

  debug_ring_2x2 u_dut (
    .clk                 (clk),
    .arst_n_i            (arst_n_i),
    .req_valid_i         (req_valid_i),
    .req_write_i         (req_write_i),
    .req_dest_i          (req_dest_i),
    .req_addr_i          (req_addr_i),
    .req_wdata_i         (req_wdata_i),
    .req_ready_o         (req_ready_o),
    .rsp_valid_o         (rsp_valid_o),
    .rsp_src_o           (rsp_src_o),
    .rsp_subtype_o       (rsp_subtype_o),
    .rsp_data_o          (rsp_data_o),
    .rsp_undeliverable_o (rsp_undeliverable_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[14:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // expected response and scratch model update on accepted writes
  function automatic exp_rsp_t predict_response(input logic write,
                                                input logic [15:0] dest,
                                                input logic [15:0] addr,
                                                input logic [15:0] wdata);
    exp_rsp_t e;
    int       tile;
    tile            = int'(dest) - `DBG_MOD_BASE_ID;
    e.src           = dest;
    e.data          = '0;
    e.undeliverable = 1'b0;
    if (tile < 0 || tile >= `DBG_NUM_TILES) begin
      // no station takes it so the request itself comes home
      e.subtype       = write ? dbg_reg_pkg::REQ_WRITE : dbg_reg_pkg::REQ_READ;
      e.src           = 16'(`DBG_HOST_ID);
      e.undeliverable = 1'b1;
    end else if (write) begin
      if (addr == dbg_reg_pkg::REG_SCRATCH) begin
        scratch_model[tile] = wdata;
        e.subtype = dbg_reg_pkg::RESP_WRITE_OK;
      end else begin
        e.subtype = dbg_reg_pkg::RESP_WRITE_ERR;
      end
    end else begin
      e.subtype = dbg_reg_pkg::RESP_READ_OK;
      case (addr)
        dbg_reg_pkg::REG_MOD_ID:      e.data = dest;
        dbg_reg_pkg::REG_MOD_VERSION: e.data = 16'h0001;
        dbg_reg_pkg::REG_SCRATCH:     e.data = scratch_model[tile];
        default:                      e.subtype = dbg_reg_pkg::RESP_READ_ERR;
      endcase
    end
    return e;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_subtype(input string name, input dbg_reg_pkg::reg_subtype_e got,
                               input dbg_reg_pkg::reg_subtype_e exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input logic [15:0] got,
                            input logic [15:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic issue_request(input logic write, input logic [15:0] dest,
                               input logic [15:0] addr, input logic [15:0] wdata);
    @(negedge clk);
    while (req_ready_o !== 1'b1) @(negedge clk);
    exp_q.push_back(predict_response(write, dest, addr, wdata));
    issued++;
    req_valid_i = 1'b1;
    req_write_i = write;
    req_dest_i  = dest;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    @(negedge clk);
    req_valid_i = 1'b0;
    wait (received == issued);
  endtask

  task automatic run_random(input int count);
    logic [15:0] write_bit;
    logic [15:0] dest;
    logic [15:0] sel;
    logic [15:0] addr;
    logic [15:0] wdata;
    for (int n = 0; n < count; n++) begin
      write_bit = take_bits(1);
      dest      = 16'(`DBG_MOD_BASE_ID) + take_bits(2);
      sel       = take_bits(3);
      // scratch weighted up so writes get read back
      case (sel)
        16'd0:          addr = dbg_reg_pkg::REG_MOD_ID;
        16'd1:          addr = dbg_reg_pkg::REG_MOD_VERSION;
        16'd6, 16'd7:   addr = take_bits(16);
        default:        addr = dbg_reg_pkg::REG_SCRATCH;
      endcase
      wdata = take_bits(16);
      issue_request(write_bit[0], dest, addr, wdata);
    end
  endtask

  // compare each response pulse with the oldest expectation
  initial begin
    exp_rsp_t e;
    forever begin
      @(negedge clk);
      if (rsp_valid_o === 1'b1) begin
        if (exp_q.size() == 0) begin
          abort_run("response arrived with no request outstanding");
        end
        e = exp_q.pop_front();
        check_subtype("rsp_subtype_o", rsp_subtype_o, e.subtype);
        check_word("rsp_src_o", rsp_src_o, e.src);
        check_flag("rsp_undeliverable_o", rsp_undeliverable_o, e.undeliverable);
        if (e.subtype == dbg_reg_pkg::RESP_READ_OK) begin
          check_word("rsp_data_o", rsp_data_o, e.data);
        end
        received++;
      end
    end
  end

  initial begin
    #(CLK_PERIOD * (NUM_REQS * 400 + 10));
    abort_run("watchdog expired before every request was answered");
  end

  initial begin
    logic [15:0] tile_addr;
    arst_n_i    = 1'b0;
    req_valid_i = 1'b0;
    req_write_i = 1'b0;
    req_dest_i  = '0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    lfsr_state  = 32'h32f5_2953;
    issued      = 0;
    received    = 0;
    for (int t = 0; t < `DBG_NUM_TILES; t++) begin
      scratch_model[t] = '0;
    end
    repeat (2) @(negedge clk);
    arst_n_i = 1'b1;

    // module id, version and an unlisted address at every tile
    for (int t = 0; t < `DBG_NUM_TILES; t++) begin
      tile_addr = 16'(`DBG_MOD_BASE_ID + t);
      issue_request(1'b0, tile_addr, dbg_reg_pkg::REG_MOD_ID, '0);
      issue_request(1'b0, tile_addr, dbg_reg_pkg::REG_MOD_VERSION, '0);
      issue_request(1'b0, tile_addr, UNLISTED_ADDR, '0);
    end

    // scratch starts at zero and then each tile holds its own value
    for (int t = 0; t < `DBG_NUM_TILES; t++) begin
      issue_request(1'b0, 16'(`DBG_MOD_BASE_ID + t), dbg_reg_pkg::REG_SCRATCH, '0);
    end
    for (int t = 0; t < `DBG_NUM_TILES; t++) begin
      issue_request(1'b1, 16'(`DBG_MOD_BASE_ID + t), dbg_reg_pkg::REG_SCRATCH,
                    take_bits(16));
    end
    for (int t = 0; t < `DBG_NUM_TILES; t++) begin
      issue_request(1'b0, 16'(`DBG_MOD_BASE_ID + t), dbg_reg_pkg::REG_SCRATCH, '0);
    end

    // read-only registers refuse writes
    issue_request(1'b1, 16'd2, dbg_reg_pkg::REG_MOD_ID, 16'hbeef);
    issue_request(1'b0, 16'd2, dbg_reg_pkg::REG_MOD_ID, '0);
    issue_request(1'b1, 16'd2, dbg_reg_pkg::REG_MOD_VERSION, 16'h5a5a);
    issue_request(1'b0, 16'd2, dbg_reg_pkg::REG_MOD_VERSION, '0);

    issue_request(1'b0, LOST_DEST, dbg_reg_pkg::REG_MOD_ID, '0);
    issue_request(1'b1, LOST_DEST, dbg_reg_pkg::REG_SCRATCH, 16'h1234);

    run_random(NUM_RANDOM);

    $display("Test passed");
    $finish;
  end

endmodule

/* debug_ring_2x2.f */
+incdir+logic
logic/dii_pkg.sv
logic/dbg_reg_pkg.sv
logic/dii_channel_if.sv
logic/host_port.sv
logic/ring_station.sv
logic/tile_debug_module.sv
logic/debug_ring_2x2.sv
testbench/tb_debug_ring.sv

/* run_sim.sh */
#!/bin/sh
# build and run the debug ring testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f debug_ring_2x2.f --top-module tb_debug_ring
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_debug_ring > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
exit 0
